//--- build.f
+incdir+.
exe_pkg.sv
alu_path.sv
mem_lane.sv
exe_commit.sv
exe_unit.sv
exe_unit_checker.sv
exe_unit_monitor.sv
exe_unit_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then judge the log
verilator --binary --timing --assert -f build.f --top-module exe_unit_tb -o sim_exe_unit \
    || exit 1
./obj_dir/sim_exe_unit +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && exit 1
grep -q "Done: no errors" sim.log || exit 1
exit 0

//--- exe_unit_tb.sv
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_unit_tb;
    import exe_pkg::*;

    localparam int RESET_CYCLES = 8;
    // alu sweep, overflow, stores, misaligned, priority, random burst with gaps, drain
    localparam int STIM_CYCLES  = 56 + 9 + 7 + 8 + 4 + 24 * 3 + 10;
    localparam int CYCLE_LIMIT  = 4 * STIM_CYCLES + RESET_CYCLES;

    // {sa, sign imm, zero imm}
    localparam logic [2:0] SRC_MODES [4] = '{3'b000, 3'b010, 3'b001, 3'b100};

    logic                   clk;
    logic                   reset;
    logic                   in_valid;
    logic [`ALU_OP_W-1:0]   in_alu_op;
    logic                   in_src1_is_sa;
    logic                   in_src2_is_imm;
    logic                   in_src2_is_imm_zero;
    logic [`DATA_W-1:0]     in_rs_value;
    logic [`DATA_W-1:0]     in_rt_value;
    exe_imm_u               in_imm;
    of_check_e              in_of_check;
    mem_op_e                in_mem_op;
    logic [`REG_ADDR_W-1:0] in_dest;
    logic                   in_gr_we;
    logic [`EX_CODE_W-1:0]  in_ex_code;
    logic                   out_valid;
    logic [`DATA_W-1:0]     out_result;
    logic [`REG_ADDR_W-1:0] out_dest;
    logic                   out_gr_we;
    logic [`EX_CODE_W-1:0]  out_ex_code;
    logic [`DATA_W-1:0]     out_bad_vaddr;
    logic                   mem_en;
    logic                   mem_wr;
    logic [3:0]             mem_wstrb;
    logic [`DATA_W-1:0]     mem_addr;
    logic [`DATA_W-1:0]     mem_wdata;
    int unsigned            error_count;
    logic [31:0]            lfsr;
    int                     cycles = 0;

    exe_unit UUT (.*);

    exe_unit_monitor u_monitor (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        repeat (n) begin
            lfsr = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [`ALU_OP_W-1:0] op_bit(input int pos);
        return {{(`ALU_OP_W-1){1'b0}}, 1'b1} << pos;
    endfunction

    task automatic issue(input logic [`ALU_OP_W-1:0] op, input logic [2:0] sel,
                         input logic [31:0] rs, input logic [31:0] rt,
                         input logic [15:0] imm, input of_check_e ofc,
                         input mem_op_e mop, input logic [`EX_CODE_W-1:0] code);
        @(posedge clk);
        in_valid            <= 1'b1;
        in_alu_op           <= op;
        in_src1_is_sa       <= sel[2];
        in_src2_is_imm      <= sel[1];
        in_src2_is_imm_zero <= sel[0];
        in_rs_value         <= rs;
        in_rt_value         <= rt;
        in_imm              <= imm;
        in_of_check         <= ofc;
        in_mem_op           <= mop;
        in_dest             <= in_dest + 5'd1;
        in_gr_we            <= !(mop inside {MEM_SW, MEM_SH, MEM_SB});
        in_ex_code          <= code;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: stimulus did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [31:0] r4;
        reset = 1'b1;
        in_valid = 1'b0;
        in_alu_op = '0;
        in_src1_is_sa = 1'b0;
        in_src2_is_imm = 1'b0;
        in_src2_is_imm_zero = 1'b0;
        in_rs_value = '0;
        in_rt_value = '0;
        in_imm = '0;
        in_of_check = OF_NONE;
        in_mem_op = MEM_NONE;
        in_dest = '0;
        in_gr_we = 1'b0;
        in_ex_code = `EXC_NONE;
        lfsr = 32'd31;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // every alu op from registers, sign and zero immediates, and sa
        for (int k = 0; k < `ALU_OP_W; k++) begin
            for (int v = 0; v < 4; v++) begin
                take_bits(32, r1);
                take_bits(32, r2);
                take_bits(16, r3);
                issue(op_bit(k), SRC_MODES[v], r1, r2, r3[15:0], OF_NONE, MEM_NONE,
                      `EXC_NONE);
            end
        end
        idle(1);

        // sign boundaries
        issue(op_bit(ALU_ADD), 3'b000, 32'h7fffffff, 32'h1, 16'h0, OF_ADD, MEM_NONE, `EXC_NONE);
        issue(op_bit(ALU_ADD), 3'b000, 32'h80000000, 32'h80000000, 16'h0, OF_ADD, MEM_NONE,
              `EXC_NONE);
        issue(op_bit(ALU_ADD), 3'b000, 32'h7fffffff, 32'hffffffff, 16'h0, OF_ADD, MEM_NONE,
              `EXC_NONE);
        issue(op_bit(ALU_ADD), 3'b010, 32'h7ffffff0, 32'h0, 16'h0010, OF_ADD, MEM_NONE,
              `EXC_NONE);
        issue(op_bit(ALU_SUB), 3'b000, 32'h80000000, 32'h1, 16'h0, OF_SUB, MEM_NONE, `EXC_NONE);
        issue(op_bit(ALU_SUB), 3'b000, 32'h0, 32'h80000000, 16'h0, OF_SUB, MEM_NONE, `EXC_NONE);
        issue(op_bit(ALU_SUB), 3'b000, 32'h7fffffff, 32'hffffffff, 16'h0, OF_SUB, MEM_NONE,
              `EXC_NONE);
        issue(op_bit(ALU_SUB), 3'b000, 32'h80000000, 32'h80000000, 16'h0, OF_SUB, MEM_NONE,
              `EXC_NONE);
        issue(op_bit(ALU_ADDU), 3'b000, 32'h7fffffff, 32'h1, 16'h0, OF_NONE, MEM_NONE,
              `EXC_NONE);
        idle(1);

        // aligned stores at every lane
        take_bits(32, r1);
        take_bits(32, r2);
        r1[1:0] = 2'b00;
        for (int off = 0; off < 4; off++) begin
            issue(op_bit(ALU_ADD), 3'b010, r1, r2, 16'h0100 + 16'(off), OF_NONE, MEM_SB,
                  `EXC_NONE);
        end
        issue(op_bit(ALU_ADD), 3'b010, r1, r2, 16'h0100, OF_NONE, MEM_SH, `EXC_NONE);
        issue(op_bit(ALU_ADD), 3'b010, r1, r2, 16'h0102, OF_NONE, MEM_SH, `EXC_NONE);
        issue(op_bit(ALU_ADD), 3'b010, r1, r2, 16'hfffc, OF_NONE, MEM_SW, `EXC_NONE);
        idle(1);

        // misaligned word and halfword, plus byte loads that never fault
        issue(op_bit(ALU_ADD), 3'b010, r1, r2, 16'h0001, OF_NONE, MEM_LW, `EXC_NONE);
        issue(op_bit(ALU_ADD), 3'b010, r1, r2, 16'h0002, OF_NONE, MEM_LW, `EXC_NONE);
        issue(op_bit(ALU_ADD), 3'b010, r1, r2, 16'h0001, OF_NONE, MEM_LH, `EXC_NONE);
        issue(op_bit(ALU_ADD), 3'b010, r1, r2, 16'h0003, OF_NONE, MEM_LHU, `EXC_NONE);
        issue(op_bit(ALU_ADD), 3'b010, r1, r2, 16'h0003, OF_NONE, MEM_SW, `EXC_NONE);
        issue(op_bit(ALU_ADD), 3'b010, r1, r2, 16'h0001, OF_NONE, MEM_SH, `EXC_NONE);
        issue(op_bit(ALU_ADD), 3'b010, r1, r2, 16'h0003, OF_NONE, MEM_LB, `EXC_NONE);
        issue(op_bit(ALU_ADD), 3'b010, r1, r2, 16'h0001, OF_NONE, MEM_LBU, `EXC_NONE);
        idle(1);

        // incoming codes beat overflow and address errors
        issue(op_bit(ALU_ADD), 3'b000, 32'h7fffffff, 32'h1, 16'h0, OF_ADD, MEM_NONE, 5'd10);
        issue(op_bit(ALU_ADD), 3'b010, r1, r2, 16'h0003, OF_NONE, MEM_SW, 5'd8);
        issue(op_bit(ALU_ADD), 3'b010, r1, r2, 16'h0002, OF_NONE, MEM_SB, 5'd0);
        issue(op_bit(ALU_ADD), 3'b010, 32'h7fffffff, r2, 16'h0002, OF_ADD, MEM_LW, `EXC_NONE);
        idle(2);

        // random burst with occasional bubbles
        for (int i = 0; i < 24; i++) begin
            take_bits(32, r1);
            take_bits(32, r2);
            take_bits(16, r3);
            take_bits(16, r4);
            issue(op_bit(int'(r4[3:0]) % `ALU_OP_W), SRC_MODES[r4[9:8]], r1, r2, r3[15:0],
                  of_check_e'(r4[11:10] % 2'd3), mem_op_e'(r4[7:4] % 4'd9),
                  (r4[14:12] == 3'b000) ? 5'd10 : `EXC_NONE);
            if (r4[15])
                idle(2);
        end
        idle(4);
        // let the last edge's compares settle
        @(negedge clk);

        $display("errors: %0d mismatches, %0d assertion failures", error_count,
                 UUT.u_checker.fail_count);
        if (error_count == 0 && UUT.u_checker.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- exe_unit_monitor.sv
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_unit_monitor (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  logic [`ALU_OP_W-1:0]   in_alu_op,
    input  logic                   in_src1_is_sa,
    input  logic                   in_src2_is_imm,
    input  logic                   in_src2_is_imm_zero,
    input  logic [`DATA_W-1:0]     in_rs_value,
    input  logic [`DATA_W-1:0]     in_rt_value,
    input  exe_pkg::exe_imm_u      in_imm,
    input  exe_pkg::of_check_e     in_of_check,
    input  exe_pkg::mem_op_e       in_mem_op,
    input  logic [`REG_ADDR_W-1:0] in_dest,
    input  logic                   in_gr_we,
    input  logic [`EX_CODE_W-1:0]  in_ex_code,
    input  logic                   out_valid,
    input  logic [`DATA_W-1:0]     out_result,
    input  logic [`REG_ADDR_W-1:0] out_dest,
    input  logic                   out_gr_we,
    input  logic [`EX_CODE_W-1:0]  out_ex_code,
    input  logic [`DATA_W-1:0]     out_bad_vaddr,
    input  logic                   mem_en,
    input  logic                   mem_wr,
    input  logic [3:0]             mem_wstrb,
    input  logic [`DATA_W-1:0]     mem_addr,
    input  logic [`DATA_W-1:0]     mem_wdata,
    output int unsigned            error_count
);
    import exe_pkg::*;

    int unsigned errors = 0;

    logic                   pend_valid;
    logic                   pend_idle;
    logic                   pend_reset;
    logic [`ALU_OP_W-1:0]   c_op;
    logic [2:0]             c_sel;
    logic [`DATA_W-1:0]     c_rs;
    logic [`DATA_W-1:0]     c_rt;
    exe_imm_u               c_imm;
    of_check_e              c_ofc;
    mem_op_e                c_mop;
    logic [`REG_ADDR_W-1:0] c_dest;
    logic                   c_we;
    logic [`EX_CODE_W-1:0]  c_code;

    logic [`DATA_W-1:0]     e_result;
    logic                   e_gr_we;
    logic [`EX_CODE_W-1:0]  e_code;
    logic [`DATA_W-1:0]     e_bad;
    logic                   e_en;
    logic                   e_wr;
    logic [3:0]             e_wstrb;
    logic [`DATA_W-1:0]     e_addr;
    logic [`DATA_W-1:0]     e_wdata;

    assign error_count = errors;

    // expected outputs of one instruction from the stage rules
    function automatic void predict(
        input  logic [`ALU_OP_W-1:0]  op,
        input  logic [2:0]            sel,
        input  logic [`DATA_W-1:0]    rs,
        input  logic [`DATA_W-1:0]    rt,
        input  exe_imm_u              imm,
        input  of_check_e             ofc,
        input  mem_op_e               mop,
        input  logic                  we,
        input  logic [`EX_CODE_W-1:0] code_in,
        output logic [`DATA_W-1:0]    result,
        output logic                  gr_we,
        output logic [`EX_CODE_W-1:0] code,
        output logic [`DATA_W-1:0]    bad,
        output logic                  en,
        output logic                  wr,
        output logic [3:0]            wstrb,
        output logic [`DATA_W-1:0]    addr,
        output logic [`DATA_W-1:0]    wdata
    );
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        logic [`DATA_W-1:0] sext;
        logic               ov;
        logic               is_ld;
        logic               is_st;
        logic               mis;
        sext = {{16{imm.value[15]}}, imm.value};
        // sel is {sa, sign imm, zero imm}
        a = sel[2] ? {27'b0, imm.fields.sa} : rs;
        b = sel[0] ? {16'b0, imm.value} : (sel[1] ? sext : rt);
        result = '0;
        case (1'b1)
            op[ALU_ADD], op[ALU_ADDU]: result = a + b;
            op[ALU_SUB], op[ALU_SUBU]: result = a - b;
            op[ALU_SLT]:  result = {31'b0, $signed(a) < $signed(b)};
            op[ALU_SLTU]: result = {31'b0, a < b};
            op[ALU_AND]:  result = a & b;
            op[ALU_NOR]:  result = ~(a | b);
            op[ALU_OR]:   result = a | b;
            op[ALU_XOR]:  result = a ^ b;
            op[ALU_SLL]:  result = b << a[4:0];
            op[ALU_SRL]:  result = b >> a[4:0];
            op[ALU_SRA]:  result = $signed(b) >>> a[4:0];
            op[ALU_LUI]:  result = {imm.value, 16'h0000};
            default:      result = '0;
        endcase
        case (ofc)
            OF_ADD:  ov = (a[31] == b[31]) && (result[31] != a[31]);
            OF_SUB:  ov = (a[31] != b[31]) && (result[31] != a[31]);
            default: ov = 1'b0;
        endcase
        addr = rs + sext;
        is_ld = (mop == MEM_LW) || (mop == MEM_LH) || (mop == MEM_LHU) ||
                (mop == MEM_LB) || (mop == MEM_LBU);
        is_st = (mop == MEM_SW) || (mop == MEM_SH) || (mop == MEM_SB);
        mis = (((mop == MEM_LW) || (mop == MEM_SW)) && (addr[1:0] != 2'b00)) ||
              (((mop == MEM_LH) || (mop == MEM_LHU) || (mop == MEM_SH)) && addr[0]);
        if (code_in != `EXC_NONE)
            code = code_in;
        else if (ov)
            code = `EXC_OV;
        else if (is_ld && mis)
            code = `EXC_ADEL;
        else if (is_st && mis)
            code = `EXC_ADES;
        else
            code = `EXC_NONE;
        gr_we = we && (code == `EXC_NONE);
        en = (is_ld || is_st) && (code == `EXC_NONE);
        wr = is_st;
        bad = ((code == `EXC_ADEL) || (code == `EXC_ADES)) ? addr : '0;
        wdata = rt;
        wstrb = 4'b0000;
        case (mop)
            MEM_SW: wstrb = 4'b1111;
            MEM_SH: begin
                wstrb = addr[1] ? 4'b1100 : 4'b0011;
                wdata = {2{rt[15:0]}};
            end
            MEM_SB: begin
                wstrb = 4'b0001 << addr[1:0];
                wdata = {4{rt[7:0]}};
            end
            default: wstrb = 4'b0000;
        endcase
        if (code != `EXC_NONE)
            wstrb = 4'b0000;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            pend_valid <= 1'b0;
            pend_idle  <= 1'b0;
            pend_reset <= 1'b1;
        end else begin
            if (pend_reset) begin
                // values left by reset
                check_val("out_valid", {31'b0, out_valid}, 32'h0);
                check_val("mem_en", {31'b0, mem_en}, 32'h0);
                check_val("mem_wr", {31'b0, mem_wr}, 32'h0);
                check_val("mem_wstrb", {28'b0, mem_wstrb}, 32'h0);
            end
            if (pend_valid) begin
                predict(c_op, c_sel, c_rs, c_rt, c_imm, c_ofc, c_mop, c_we, c_code,
                        e_result, e_gr_we, e_code, e_bad, e_en, e_wr, e_wstrb,
                        e_addr, e_wdata);
                check_val("out_valid", {31'b0, out_valid}, 32'h1);
                check_val("out_result", out_result, e_result);
                check_val("out_dest", {27'b0, out_dest}, {27'b0, c_dest});
                check_val("out_gr_we", {31'b0, out_gr_we}, {31'b0, e_gr_we});
                check_val("out_ex_code", {27'b0, out_ex_code}, {27'b0, e_code});
                check_val("out_bad_vaddr", out_bad_vaddr, e_bad);
                check_val("mem_en", {31'b0, mem_en}, {31'b0, e_en});
                check_val("mem_wr", {31'b0, mem_wr}, {31'b0, e_wr});
                check_val("mem_wstrb", {28'b0, mem_wstrb}, {28'b0, e_wstrb});
                check_val("mem_addr", mem_addr, e_addr);
                check_val("mem_wdata", mem_wdata, e_wdata);
            end else if (pend_idle) begin
                // bubble cycle
                check_val("out_valid", {31'b0, out_valid}, 32'h0);
                check_val("mem_en", {31'b0, mem_en}, 32'h0);
                check_val("mem_wstrb", {28'b0, mem_wstrb}, 32'h0);
            end
            pend_reset <= 1'b0;
            pend_valid <= in_valid;
            pend_idle  <= !in_valid;
            if (in_valid) begin
                c_op   <= in_alu_op;
                c_sel  <= {in_src1_is_sa, in_src2_is_imm, in_src2_is_imm_zero};
                c_rs   <= in_rs_value;
                c_rt   <= in_rt_value;
                c_imm  <= in_imm;
                c_ofc  <= in_of_check;
                c_mop  <= in_mem_op;
                c_dest <= in_dest;
                c_we   <= in_gr_we;
                c_code <= in_ex_code;
            end
        end
    end

endmodule

//--- exe_unit_checker.sv
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_unit_checker (
    input logic                  clk,
    input logic                  reset,
    input logic                  in_valid,
    input logic                  out_valid,
    input logic [`EX_CODE_W-1:0] out_ex_code,
    input logic                  mem_en,
    input logic                  mem_wr,
    input logic [3:0]            mem_wstrb
);

    int unsigned fail_count = 0;

    valid_low_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high in the cycle after reset");
        end

    // one register stage between strobe and result
    valid_follows_strobe: assert property (
        @(posedge clk) !reset |=> (out_valid == $past(in_valid)))
        else begin
            fail_count++;
            $error("out_valid does not follow in_valid by one cycle");
        end

    mem_en_without_exc: assert property (
        @(posedge clk) mem_en |-> (out_ex_code == `EXC_NONE))
        else begin
            fail_count++;
            $error("memory request issued with an exception pending");
        end

    wstrb_only_on_write: assert property (
        @(posedge clk) (mem_wstrb != 4'b0000) |-> (mem_wr && mem_en))
        else begin
            fail_count++;
            $error("byte strobes set without an enabled write");
        end

endmodule

bind exe_unit exe_unit_checker u_checker (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .out_valid   (out_valid),
    .out_ex_code (out_ex_code),
    .mem_en      (mem_en),
    .mem_wr      (mem_wr),
    .mem_wstrb   (mem_wstrb)
);

//--- exe_unit.sv
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  logic [`ALU_OP_W-1:0]   in_alu_op,
    input  logic                   in_src1_is_sa,
    input  logic                   in_src2_is_imm,
    input  logic                   in_src2_is_imm_zero,
    input  logic [`DATA_W-1:0]     in_rs_value,
    input  logic [`DATA_W-1:0]     in_rt_value,
    input  exe_pkg::exe_imm_u      in_imm,
    input  exe_pkg::of_check_e     in_of_check,
    input  exe_pkg::mem_op_e       in_mem_op,
    input  logic [`REG_ADDR_W-1:0] in_dest,
    input  logic                   in_gr_we,
    input  logic [`EX_CODE_W-1:0]  in_ex_code,
    output logic                   out_valid,
    output logic [`DATA_W-1:0]     out_result,
    output logic [`REG_ADDR_W-1:0] out_dest,
    output logic                   out_gr_we,
    output logic [`EX_CODE_W-1:0]  out_ex_code,
    output logic [`DATA_W-1:0]     out_bad_vaddr,
    output logic                   mem_en,
    output logic                   mem_wr,
    output logic [3:0]             mem_wstrb,
    output logic [`DATA_W-1:0]     mem_addr,
    output logic [`DATA_W-1:0]     mem_wdata
);

    logic [`DATA_W-1:0] alu_result;
    logic               overflow;
    logic [`DATA_W-1:0] mem_addr_c;
    logic [3:0]         wstrb_c;
    logic [`DATA_W-1:0] wdata_c;
    logic               mem_req_c;
    logic               mem_wr_c;
    logic               ade_load;
    logic               ade_store;

    alu_path u_alu_path (
        .alu_op           (in_alu_op),
        .src1_is_sa       (in_src1_is_sa),
        .src2_is_imm      (in_src2_is_imm),
        .src2_is_imm_zero (in_src2_is_imm_zero),
        .rs_value         (in_rs_value),
        .rt_value         (in_rt_value),
        .imm              (in_imm),
        .of_check         (in_of_check),
        .alu_result       (alu_result),
        .overflow         (overflow)
    );

    // runs beside the alu on the same decoded fields
    mem_lane u_mem_lane (
        .mem_op     (in_mem_op),
        .rs_value   (in_rs_value),
        .rt_value   (in_rt_value),
        .imm        (in_imm),
        .mem_addr_c (mem_addr_c),
        .wstrb_c    (wstrb_c),
        .wdata_c    (wdata_c),
        .mem_req_c  (mem_req_c),
        .mem_wr_c   (mem_wr_c),
        .ade_load   (ade_load),
        .ade_store  (ade_store)
    );

    exe_commit u_commit (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .ex_code_in    (in_ex_code),
        .dest          (in_dest),
        .gr_we         (in_gr_we),
        .alu_result    (alu_result),
        .overflow      (overflow),
        .mem_addr_c    (mem_addr_c),
        .wstrb_c       (wstrb_c),
        .wdata_c       (wdata_c),
        .mem_req_c     (mem_req_c),
        .mem_wr_c      (mem_wr_c),
        .ade_load      (ade_load),
        .ade_store     (ade_store),
        .out_valid     (out_valid),
        .out_result    (out_result),
        .out_dest      (out_dest),
        .out_gr_we     (out_gr_we),
        .out_ex_code   (out_ex_code),
        .out_bad_vaddr (out_bad_vaddr),
        .mem_en        (mem_en),
        .mem_wr        (mem_wr),
        .mem_wstrb     (mem_wstrb),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata)
    );

endmodule

//--- exe_commit.sv
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_commit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  logic [`EX_CODE_W-1:0]  ex_code_in,
    input  logic [`REG_ADDR_W-1:0] dest,
    input  logic                   gr_we,
    input  logic [`DATA_W-1:0]     alu_result,
    input  logic                   overflow,
    input  logic [`DATA_W-1:0]     mem_addr_c,
    input  logic [3:0]             wstrb_c,
    input  logic [`DATA_W-1:0]     wdata_c,
    input  logic                   mem_req_c,
    input  logic                   mem_wr_c,
    input  logic                   ade_load,
    input  logic                   ade_store,
    output logic                   out_valid,
    output logic [`DATA_W-1:0]     out_result,
    output logic [`REG_ADDR_W-1:0] out_dest,
    output logic                   out_gr_we,
    output logic [`EX_CODE_W-1:0]  out_ex_code,
    output logic [`DATA_W-1:0]     out_bad_vaddr,
    output logic                   mem_en,
    output logic                   mem_wr,
    output logic [3:0]             mem_wstrb,
    output logic [`DATA_W-1:0]     mem_addr,
    output logic [`DATA_W-1:0]     mem_wdata
);

    logic [`EX_CODE_W-1:0] ex_code_n;
    logic                  has_exc;
    logic                  addr_exc;

    // earlier stages win, then overflow, then address errors
    assign ex_code_n = (ex_code_in != `EXC_NONE) ? ex_code_in :
                       overflow                  ? `EXC_OV    :
                       ade_load                  ? `EXC_ADEL  :
                       ade_store                 ? `EXC_ADES  :
                                                   `EXC_NONE;

    assign has_exc  = (ex_code_n != `EXC_NONE);
    assign addr_exc = (ex_code_n == `EXC_ADEL) || (ex_code_n == `EXC_ADES);

    // idle cycles must drop valid and the memory request
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_gr_we <= 1'b0;
            mem_en    <= 1'b0;
            mem_wr    <= 1'b0;
            mem_wstrb <= 4'b0000;
        end else begin
            out_valid <= in_valid;
            mem_en    <= in_valid && mem_req_c && !has_exc;
            mem_wstrb <= (in_valid && !has_exc) ? wstrb_c : 4'b0000;
            if (in_valid) begin
                out_gr_we <= gr_we && !has_exc;
                mem_wr    <= mem_wr_c;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_result    <= alu_result;
            out_dest      <= dest;
            out_ex_code   <= ex_code_n;
            out_bad_vaddr <= addr_exc ? mem_addr_c : '0;
            mem_addr      <= mem_addr_c;
            mem_wdata     <= wdata_c;
        end
    end

endmodule

//--- mem_lane.sv
`timescale 1ns/1ps
`include "exe_cfg.svh"

module mem_lane (
    input  exe_pkg::mem_op_e    mem_op,
    input  logic [`DATA_W-1:0]  rs_value,
    input  logic [`DATA_W-1:0]  rt_value,
    input  exe_pkg::exe_imm_u   imm,
    output logic [`DATA_W-1:0]  mem_addr_c,
    output logic [3:0]          wstrb_c,
    output logic [`DATA_W-1:0]  wdata_c,
    output logic                mem_req_c,
    output logic                mem_wr_c,
    output logic                ade_load,
    output logic                ade_store
);
    import exe_pkg::*;

    logic       is_load;
    logic       is_store;
    logic       word_acc;
    logic       half_acc;
    logic       misaligned;
    logic [1:0] byte_off;

    // own adder keeps the address off the alu path
    assign mem_addr_c = rs_value + {{(`DATA_W-16){imm.value[15]}}, imm.value};
    assign byte_off   = mem_addr_c[1:0];

    assign is_load  = (mem_op == MEM_LW) || (mem_op == MEM_LH) || (mem_op == MEM_LHU) ||
                      (mem_op == MEM_LB) || (mem_op == MEM_LBU);
    assign is_store = (mem_op == MEM_SW) || (mem_op == MEM_SH) || (mem_op == MEM_SB);

    assign word_acc = (mem_op == MEM_LW) || (mem_op == MEM_SW);
    assign half_acc = (mem_op == MEM_LH) || (mem_op == MEM_LHU) || (mem_op == MEM_SH);

    assign misaligned = (word_acc && (byte_off != 2'b00)) || (half_acc && byte_off[0]);

    assign ade_load  = is_load && misaligned;
    assign ade_store = is_store && misaligned;

    assign mem_req_c = is_load || is_store;
    assign mem_wr_c  = is_store;

    // replicate narrow store data across the word
    always_comb begin
        case (mem_op)
            MEM_SB:  wdata_c = {4{rt_value[7:0]}};
            MEM_SH:  wdata_c = {2{rt_value[15:0]}};
            default: wdata_c = rt_value;
        endcase
    end

    always_comb begin
        case (mem_op)
            MEM_SB: begin
                wstrb_c = 4'b0001 << byte_off;
            end
            MEM_SH: begin
                wstrb_c = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            MEM_SW: begin
                wstrb_c = 4'b1111;
            end
            // loads and non-memory ops write nothing
            default: begin
                wstrb_c = 4'b0000;
            end
        endcase
    end

endmodule

//--- alu_path.sv
`timescale 1ns/1ps
`include "exe_cfg.svh"

module alu_path (
    input  logic [`ALU_OP_W-1:0] alu_op,
    input  logic                 src1_is_sa,
    input  logic                 src2_is_imm,
    input  logic                 src2_is_imm_zero,
    input  logic [`DATA_W-1:0]   rs_value,
    input  logic [`DATA_W-1:0]   rt_value,
    input  exe_pkg::exe_imm_u    imm,
    input  exe_pkg::of_check_e   of_check,
    output logic [`DATA_W-1:0]   alu_result,
    output logic                 overflow
);
    import exe_pkg::*;

    logic [`DATA_W-1:0] src1;
    logic [`DATA_W-1:0] src2;
    logic [`DATA_W-1:0] sum;
    logic [`DATA_W-1:0] diff;
    logic [`DATA_W-1:0] slt_res;
    logic [`DATA_W-1:0] sltu_res;
    logic [`DATA_W-1:0] sll_res;
    logic [`DATA_W-1:0] srl_res;
    logic [`DATA_W-1:0] sra_res;
    logic [`DATA_W-1:0] lui_res;
    logic [4:0]         shamt;
    logic               sign1;
    logic               sign2;
    logic               sign_res;

    // shift amount comes from instr[10:6]
    assign src1 = src1_is_sa ? {{(`DATA_W-5){1'b0}}, imm.fields.sa} : rs_value;

    // zero extension wins over sign extension
    assign src2 = src2_is_imm_zero ? {{(`DATA_W-16){1'b0}}, imm.value} :
                  src2_is_imm      ? {{(`DATA_W-16){imm.value[15]}}, imm.value} :
                                     rt_value;

    assign sum   = src1 + src2;
    assign diff  = src1 - src2;
    assign shamt = src1[4:0];

    assign slt_res  = {{(`DATA_W-1){1'b0}}, $signed(src1) < $signed(src2)};
    assign sltu_res = {{(`DATA_W-1){1'b0}}, src1 < src2};
    assign sll_res  = src2 << shamt;
    assign srl_res  = src2 >> shamt;
    assign sra_res  = $signed(src2) >>> shamt;
    assign lui_res  = {imm.value, 16'h0000};

    // one-hot select as an and-or tree
    always_comb begin
        alu_result = '0;
        if (alu_op[ALU_ADD] | alu_op[ALU_ADDU])
            alu_result = alu_result | sum;
        if (alu_op[ALU_SUB] | alu_op[ALU_SUBU])
            alu_result = alu_result | diff;
        if (alu_op[ALU_SLT])
            alu_result = alu_result | slt_res;
        if (alu_op[ALU_SLTU])
            alu_result = alu_result | sltu_res;
        if (alu_op[ALU_AND])
            alu_result = alu_result | (src1 & src2);
        if (alu_op[ALU_NOR])
            alu_result = alu_result | ~(src1 | src2);
        if (alu_op[ALU_OR])
            alu_result = alu_result | (src1 | src2);
        if (alu_op[ALU_XOR])
            alu_result = alu_result | (src1 ^ src2);
        if (alu_op[ALU_SLL])
            alu_result = alu_result | sll_res;
        if (alu_op[ALU_SRL])
            alu_result = alu_result | srl_res;
        if (alu_op[ALU_SRA])
            alu_result = alu_result | sra_res;
        if (alu_op[ALU_LUI])
            alu_result = alu_result | lui_res;
    end

    assign sign1    = src1[`DATA_W-1];
    assign sign2    = src2[`DATA_W-1];
    assign sign_res = alu_result[`DATA_W-1];

    // signed overflow, only when decode asked for the check
    always_comb begin
        case (of_check)
            OF_ADD:  overflow = (sign1 == sign2) && (sign_res != sign1);
            OF_SUB:  overflow = (sign1 != sign2) && (sign_res != sign1);
            default: overflow = 1'b0;
        endcase
    end

endmodule

//--- exe_pkg.sv
package exe_pkg;

    // bit positions in the one-hot alu operation word
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_ADDU,
        ALU_SUBU
    } alu_op_e;

    typedef enum logic [1:0] {
        OF_NONE,
        OF_ADD,
        OF_SUB
    } of_check_e;

    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LW,
        MEM_LH,
        MEM_LHU,
        MEM_LB,
        MEM_LBU,
        MEM_SW,
        MEM_SH,
        MEM_SB
    } mem_op_e;

    // instr[15:0] seen as an immediate or as the r-type sa field
    typedef union packed {
        logic [15:0] value;
        struct packed {
            logic [4:0] upper;
            logic [4:0] sa;
            logic [5:0] funct;
        } fields;
    } exe_imm_u;

endpackage

//--- exe_cfg.svh
`ifndef EXE_CFG_SVH
`define EXE_CFG_SVH

// datapath widths
`define DATA_W      32
`define REG_ADDR_W  5

// one bit per alu operation
`define ALU_OP_W    14

// cp0 cause exception codes
`define EX_CODE_W   5

// no exception pending
`define EXC_NONE    5'h1f

// address error on load
`define EXC_ADEL    5'd4

// address error on store
`define EXC_ADES    5'd5

// signed arithmetic overflow
`define EXC_OV      5'd12

`endif
